// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= robCoreTb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "pass found in $(LOG)" || \
		{ echo "pass not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
hdl/robPkg.sv
hdl/dispatchStage.sv
hdl/reorderBuffer.sv
hdl/retireUnit.sv
hdl/robCore.sv
test/robCore_assertions.sv
test/robCoreTb.sv

// ==== hdl/dispatchStage.sv ====
`timescale 1ns/100ps

module dispatchStage import robPkg::*; (
    input  logic                clk,
    input  logic                rst,

    // instruction input
    input  logic                insValid,
    input  logic [XLEN-1:0]     insPc,
    input  logic [REG_BITS-1:0] insRd,
    output logic                insReady,

    // invalidate and redirect
    input  logic                invValid,
    input  logic [SQN_BITS-1:0] invSqN,
    input  logic                redirValid,

    // window from the buffer
    input  logic [SQN_BITS-1:0] headSqN,
    input  logic [SQN_BITS-1:0] maxSqN,

    // enqueue toward the buffer
    output logic                enqValid,
    output logic [SQN_BITS-1:0] enqSqN,
    output logic [XLEN-1:0]     enqPc,
    output logic [REG_BITS-1:0] enqRd
);

    logic [SQN_BITS-1:0] nextSqN;
    logic                accept;

    // stall once the next number falls outside the buffer window,
    // and hold off while the buffer is being flushed or trimmed
    assign insReady = !sqnAfter(nextSqN, maxSqN) && !invValid && !redirValid;
    assign accept   = insValid && insReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            nextSqN  <= '0;
            enqValid <= 1'b0;
        end else if (redirValid) begin
            // restart right after the retired flagged instruction
            nextSqN  <= headSqN;
            enqValid <= 1'b0;
        end else if (invValid) begin
            nextSqN  <= invSqN + SQN_BITS'(1);
            enqValid <= 1'b0;
        end else begin
            enqValid <= accept;
            if (accept) begin
                nextSqN <= nextSqN + SQN_BITS'(1);
            end
        end
    end

    // enqueue payload, only meaningful while enqValid is high
    always_ff @(posedge clk) begin
        if (accept) begin
            enqSqN <= nextSqN;
            enqPc  <= insPc;
            enqRd  <= insRd;
        end
    end

endmodule

// ==== hdl/reorderBuffer.sv ====
`timescale 1ns/100ps

module reorderBuffer import robPkg::*; #(
    parameter int ROB_LENGTH   = 16,
    parameter int COMMIT_WIDTH = 2,
    parameter int WB_PORTS     = 2
) (
    input  logic                    clk,
    input  logic                    rst,

    // enqueue from dispatch
    input  logic                    enqValid,
    input  logic [SQN_BITS-1:0]     enqSqN,
    input  logic [XLEN-1:0]         enqPc,
    input  logic [REG_BITS-1:0]     enqRd,

    // writeback ports
    input  logic [WB_PORTS-1:0]     wbValid,
    input  logic [SQN_BITS-1:0]     wbSqN [WB_PORTS-1:0],
    input  RobFlag                  wbFlag [WB_PORTS-1:0],
    input  WbInfo                   wbInfo [WB_PORTS-1:0],

    // invalidate and redirect
    input  logic                    invValid,
    input  logic [SQN_BITS-1:0]     invSqN,
    input  logic                    redirValid,

    // window
    output logic [SQN_BITS-1:0]     headSqN,
    output logic [SQN_BITS-1:0]     maxSqN,

    // commit lanes
    output logic [COMMIT_WIDTH-1:0] comValid,
    output logic [SQN_BITS-1:0]     comSqN [COMMIT_WIDTH-1:0],
    output logic [XLEN-1:0]         comPc [COMMIT_WIDTH-1:0],
    output logic [REG_BITS-1:0]     comRd [COMMIT_WIDTH-1:0],
    output RobFlag                  comFlag [COMMIT_WIDTH-1:0],
    output WbInfo                   comInfo [COMMIT_WIDTH-1:0]
);

    localparam int IDX_BITS = $clog2(ROB_LENGTH);

    // entry storage, indexed by the low sequence number bits
    logic [ROB_LENGTH-1:0] entValid;
    logic [ROB_LENGTH-1:0] entExec;
    logic [SQN_BITS-1:0]   entSqN [ROB_LENGTH];
    logic [XLEN-1:0]       entPc [ROB_LENGTH];
    logic [REG_BITS-1:0]   entRd [ROB_LENGTH];
    RobFlag                entFlag [ROB_LENGTH];
    WbInfo                 entInfo [ROB_LENGTH];

    // set after a flagged commit, held until the redirect arrives
    logic                  comBlocked;

    logic [IDX_BITS-1:0]   laneIdx [COMMIT_WIDTH];
    logic [IDX_BITS-1:0]   enqIdx;
    logic                  multiOk;
    logic                  commitOpen;
    logic                  doMulti;
    logic                  doSingle;
    logic                  enqOk;
    logic [WB_PORTS-1:0]   wbOk;

    assign maxSqN = headSqN + SQN_BITS'(ROB_LENGTH - 1);
    assign enqIdx = enqSqN[IDX_BITS-1:0];

    // full-width commit needs every head lane done and unflagged
    always_comb begin
        multiOk = 1'b1;
        for (int l = 0; l < COMMIT_WIDTH; l++) begin
            laneIdx[l] = headSqN[IDX_BITS-1:0] + IDX_BITS'(l);
            if (!entValid[laneIdx[l]] || !entExec[laneIdx[l]] ||
                    entFlag[laneIdx[l]] != flagNone) begin
                multiOk = 1'b0;
            end
        end
    end

    assign commitOpen = !comBlocked && !invValid && !redirValid;
    assign doMulti    = commitOpen && multiOk;
    assign doSingle   = commitOpen && !multiOk &&
                        entValid[laneIdx[0]] && entExec[laneIdx[0]];

    // drop enqueues and writebacks that the same-cycle invalidate kills
    assign enqOk = enqValid && !redirValid && !(invValid && sqnAfter(enqSqN, invSqN));

    always_comb begin
        for (int p = 0; p < WB_PORTS; p++) begin
            wbOk[p] = wbValid[p] && !redirValid && !(invValid && sqnAfter(wbSqN[p], invSqN));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headSqN    <= '0;
            comBlocked <= 1'b0;
            comValid   <= '0;
            entValid   <= '0;
            entExec    <= '0;
        end else if (redirValid) begin
            // head already sits one past the flagged entry
            comBlocked <= 1'b0;
            comValid   <= '0;
            entValid   <= '0;
            entExec    <= '0;
        end else begin
            comValid <= '0;

            if (invValid) begin
                for (int e = 0; e < ROB_LENGTH; e++) begin
                    if (sqnAfter(entSqN[e], invSqN)) begin
                        entValid[e] <= 1'b0;
                        entExec[e]  <= 1'b0;
                    end
                end
            end

            if (doMulti) begin
                for (int l = 0; l < COMMIT_WIDTH; l++) begin
                    entValid[laneIdx[l]] <= 1'b0;
                    entExec[laneIdx[l]]  <= 1'b0;
                    comValid[l]          <= 1'b1;
                end
                headSqN <= headSqN + SQN_BITS'(COMMIT_WIDTH);
            end else if (doSingle) begin
                entValid[laneIdx[0]] <= 1'b0;
                entExec[laneIdx[0]]  <= 1'b0;
                comValid[0]          <= 1'b1;
                comBlocked           <= entFlag[laneIdx[0]] != flagNone;
                headSqN              <= headSqN + SQN_BITS'(1);
            end

            if (enqOk) begin
                entValid[enqIdx] <= 1'b1;
                entExec[enqIdx]  <= 1'b0;
            end

            // a writeback in the enqueue cycle still counts
            for (int p = 0; p < WB_PORTS; p++) begin
                if (wbOk[p]) begin
                    entExec[wbSqN[p][IDX_BITS-1:0]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enqOk) begin
            entSqN[enqIdx] <= enqSqN;
            entPc[enqIdx]  <= enqPc;
            entRd[enqIdx]  <= enqRd;
        end

        for (int p = 0; p < WB_PORTS; p++) begin
            if (wbOk[p]) begin
                entFlag[wbSqN[p][IDX_BITS-1:0]] <= wbFlag[p];
                entInfo[wbSqN[p][IDX_BITS-1:0]] <= wbInfo[p];
            end
        end

        for (int l = 0; l < COMMIT_WIDTH; l++) begin
            if (doMulti || (doSingle && l == 0)) begin
                comSqN[l]  <= headSqN + SQN_BITS'(l);
                comPc[l]   <= entPc[laneIdx[l]];
                comRd[l]   <= entRd[laneIdx[l]];
                comFlag[l] <= entFlag[laneIdx[l]];
                comInfo[l] <= entInfo[laneIdx[l]];
            end
        end
    end

endmodule

// ==== hdl/retireUnit.sv ====
`timescale 1ns/100ps

module retireUnit import robPkg::*; #(
    parameter int              COMMIT_WIDTH = 2,
    parameter logic [XLEN-1:0] TRAP_VECTOR  = 32'h100
) (
    input  logic                    clk,
    input  logic                    rst,

    // commit lanes from the buffer
    input  logic [COMMIT_WIDTH-1:0] comValid,
    input  logic [SQN_BITS-1:0]     comSqN [COMMIT_WIDTH-1:0],
    input  logic [XLEN-1:0]         comPc [COMMIT_WIDTH-1:0],
    input  logic [REG_BITS-1:0]     comRd [COMMIT_WIDTH-1:0],
    input  RobFlag                  comFlag [COMMIT_WIDTH-1:0],
    input  WbInfo                   comInfo [COMMIT_WIDTH-1:0],

    // retire stream
    output logic [COMMIT_WIDTH-1:0] retValid,
    output logic [SQN_BITS-1:0]     retSqN [COMMIT_WIDTH-1:0],
    output logic [REG_BITS-1:0]     retRd [COMMIT_WIDTH-1:0],
    output logic [XLEN-1:0]         retValue [COMMIT_WIDTH-1:0],

    // status
    output logic [XLEN-1:0]         retireCount,
    output logic [CAUSE_BITS-1:0]   trapCause,
    output logic [XLEN-1:0]         trapPc,
    output logic                    halted,

    // redirect
    output logic                    redirValid,
    output logic [XLEN-1:0]         redirPc,

    // debug read port
    input  logic [REG_BITS-1:0]     archAddr,
    output logic [XLEN-1:0]         archData
);

    logic [XLEN-1:0] regFile [2**REG_BITS];
    logic [XLEN-1:0] laneCount;

    always_comb begin
        laneCount = '0;
        for (int l = 0; l < COMMIT_WIDTH; l++) begin
            laneCount = laneCount + XLEN'(comValid[l]);
        end
    end

    // later lanes win when two lanes name the same register
    always_ff @(posedge clk) begin
        for (int l = 0; l < COMMIT_WIDTH; l++) begin
            if (comValid[l] && comFlag[l] == flagNone && comRd[l] != '0) begin
                regFile[comRd[l]] <= comInfo[l].result;
            end
        end
    end

    // x0 reads as zero
    assign archData = (archAddr == '0) ? '0 : regFile[archAddr];

    always_ff @(posedge clk) begin
        for (int l = 0; l < COMMIT_WIDTH; l++) begin
            retSqN[l] <= comSqN[l];
            // flagged lanes retire without a destination
            if (comFlag[l] == flagNone) begin
                retRd[l]    <= comRd[l];
                retValue[l] <= comInfo[l].result;
            end else begin
                retRd[l]    <= '0;
                retValue[l] <= '0;
            end
        end
        // only lane 0 can carry a flag
        if (comValid[0]) begin
            redirPc <= (comFlag[0] == flagTrap) ? TRAP_VECTOR : comPc[0] + XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retValid    <= '0;
            retireCount <= '0;
            trapCause   <= '0;
            trapPc      <= '0;
            halted      <= 1'b0;
            redirValid  <= 1'b0;
        end else begin
            retValid    <= comValid;
            retireCount <= retireCount + laneCount;
            redirValid  <= comValid[0] && comFlag[0] != flagNone;
            if (comValid[0] && comFlag[0] == flagTrap) begin
                trapCause <= comInfo[0].trap.cause;
                trapPc    <= comPc[0];
            end
            // sticky until reset
            if (comValid[0] && comFlag[0] == flagBreak) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/robCore.sv ====
`timescale 1ns/100ps

module robCore import robPkg::*; #(
    parameter int              ROB_LENGTH   = 16,
    parameter int              COMMIT_WIDTH = 2,
    parameter int              WB_PORTS     = 2,
    parameter logic [XLEN-1:0] TRAP_VECTOR  = 32'h100
) (
    input  logic                    clk,
    input  logic                    rst,

    // instruction input
    input  logic                    insValid,
    input  logic [XLEN-1:0]         insPc,
    input  logic [REG_BITS-1:0]     insRd,
    output logic                    insReady,

    // writeback ports
    input  logic [WB_PORTS-1:0]     wbValid,
    input  logic [SQN_BITS-1:0]     wbSqN [WB_PORTS-1:0],
    input  RobFlag                  wbFlag [WB_PORTS-1:0],
    input  WbInfo                   wbInfo [WB_PORTS-1:0],

    // mispredict invalidate
    input  logic                    invValid,
    input  logic [SQN_BITS-1:0]     invSqN,

    // retire stream
    output logic [COMMIT_WIDTH-1:0] retValid,
    output logic [SQN_BITS-1:0]     retSqN [COMMIT_WIDTH-1:0],
    output logic [REG_BITS-1:0]     retRd [COMMIT_WIDTH-1:0],
    output logic [XLEN-1:0]         retValue [COMMIT_WIDTH-1:0],

    // status and redirect
    output logic [XLEN-1:0]         retireCount,
    output logic [CAUSE_BITS-1:0]   trapCause,
    output logic [XLEN-1:0]         trapPc,
    output logic                    halted,
    output logic                    redirValid,
    output logic [XLEN-1:0]         redirPc,

    // debug read port
    input  logic [REG_BITS-1:0]     archAddr,
    output logic [XLEN-1:0]         archData
);

    logic                    enqValid;
    logic [SQN_BITS-1:0]     enqSqN;
    logic [XLEN-1:0]         enqPc;
    logic [REG_BITS-1:0]     enqRd;
    logic [SQN_BITS-1:0]     headSqN;
    logic [SQN_BITS-1:0]     maxSqN;
    logic [COMMIT_WIDTH-1:0] comValid;
    logic [SQN_BITS-1:0]     comSqN [COMMIT_WIDTH-1:0];
    logic [XLEN-1:0]         comPc [COMMIT_WIDTH-1:0];
    logic [REG_BITS-1:0]     comRd [COMMIT_WIDTH-1:0];
    RobFlag                  comFlag [COMMIT_WIDTH-1:0];
    WbInfo                   comInfo [COMMIT_WIDTH-1:0];

    dispatchStage dispatch (
        .clk, .rst,
        .insValid, .insPc, .insRd, .insReady,
        .invValid, .invSqN, .redirValid,
        .headSqN, .maxSqN,
        .enqValid, .enqSqN, .enqPc, .enqRd
    );

    reorderBuffer #(
        .ROB_LENGTH(ROB_LENGTH), .COMMIT_WIDTH(COMMIT_WIDTH), .WB_PORTS(WB_PORTS)
    ) rob (
        .clk, .rst,
        .enqValid, .enqSqN, .enqPc, .enqRd,
        .wbValid, .wbSqN, .wbFlag, .wbInfo,
        .invValid, .invSqN, .redirValid,
        .headSqN, .maxSqN,
        .comValid, .comSqN, .comPc, .comRd, .comFlag, .comInfo
    );

    // redirect loops back into dispatch and the buffer
    retireUnit #(
        .COMMIT_WIDTH(COMMIT_WIDTH), .TRAP_VECTOR(TRAP_VECTOR)
    ) retire (
        .clk, .rst,
        .comValid, .comSqN, .comPc, .comRd, .comFlag, .comInfo,
        .retValid, .retSqN, .retRd, .retValue,
        .retireCount, .trapCause, .trapPc, .halted,
        .redirValid, .redirPc,
        .archAddr, .archData
    );

endmodule

// ==== hdl/robPkg.sv ====
package robPkg;

    // sequence number width, order is decided by signed difference
    localparam int SQN_BITS = 6;

    // architectural register name width
    localparam int REG_BITS = 5;

    // data and pc width
    localparam int XLEN = 32;

    // trap cause field width inside the trap view
    localparam int CAUSE_BITS = 4;

    // how an executed instruction completed
    typedef enum logic [1:0] {
        flagNone  = 2'd0,
        flagTrap  = 2'd1,
        flagFence = 2'd2,
        flagBreak = 2'd3
    } RobFlag;

    // trap view of a writeback word
    typedef struct packed {
        logic [CAUSE_BITS-1:0]      cause;
        logic [XLEN-CAUSE_BITS-1:0] value;
    } TrapView;

    // one writeback word, decoded by the flag that came with it
    typedef union packed {
        logic [XLEN-1:0] result;
        TrapView         trap;
    } WbInfo;

    // true when sequence number a is younger than b
    function automatic logic sqnAfter(input logic [SQN_BITS-1:0] a,
                                      input logic [SQN_BITS-1:0] b);
        logic signed [SQN_BITS-1:0] diff;
        diff = a - b;
        return diff > 0;
    endfunction

endpackage

// ==== test/robCoreTb.sv ====
`timescale 1ns/100ps

module robCoreTb import robPkg::*; ();

    localparam int              ROB_LENGTH   = 16;
    localparam int              COMMIT_WIDTH = 2;
    localparam int              WB_PORTS     = 2;
    localparam logic [XLEN-1:0] TRAP_VECTOR  = 32'h100;
    localparam int              TIMEOUT      = 200;

    logic                    clk;
    logic                    rst;
    logic                    insValid;
    logic [XLEN-1:0]         insPc;
    logic [REG_BITS-1:0]     insRd;
    logic                    insReady;
    logic [WB_PORTS-1:0]     wbValid;
    logic [SQN_BITS-1:0]     wbSqN [WB_PORTS-1:0];
    RobFlag                  wbFlag [WB_PORTS-1:0];
    WbInfo                   wbInfo [WB_PORTS-1:0];
    logic                    invValid;
    logic [SQN_BITS-1:0]     invSqN;
    logic [COMMIT_WIDTH-1:0] retValid;
    logic [SQN_BITS-1:0]     retSqN [COMMIT_WIDTH-1:0];
    logic [REG_BITS-1:0]     retRd [COMMIT_WIDTH-1:0];
    logic [XLEN-1:0]         retValue [COMMIT_WIDTH-1:0];
    logic [XLEN-1:0]         retireCount;
    logic [CAUSE_BITS-1:0]   trapCause;
    logic [XLEN-1:0]         trapPc;
    logic                    halted;
    logic                    redirValid;
    logic [XLEN-1:0]         redirPc;
    logic [REG_BITS-1:0]     archAddr;
    logic [XLEN-1:0]         archData;

    // reference model: per sequence number info, program-order queue, registers
    logic [REG_BITS-1:0]     sqnRd [2**SQN_BITS];
    logic [XLEN-1:0]         sqnVal [2**SQN_BITS];
    RobFlag                  sqnFlag [2**SQN_BITS];
    logic [SQN_BITS-1:0]     expQ [$];
    logic [SQN_BITS-1:0]     modelSqN;
    int                      expCount;
    logic [XLEN-1:0]         regModel [2**REG_BITS];
    logic [2**REG_BITS-1:0]  regKnown;
    logic                    redirSeen;
    logic [XLEN-1:0]         redirSeenPc;
    int                      errors;
    int                      testsRun;
    int                      testsFailed;

    robCore #(
        .ROB_LENGTH(ROB_LENGTH), .COMMIT_WIDTH(COMMIT_WIDTH),
        .WB_PORTS(WB_PORTS), .TRAP_VECTOR(TRAP_VECTOR)
    ) uut (
        .clk, .rst,
        .insValid, .insPc, .insRd, .insReady,
        .wbValid, .wbSqN, .wbFlag, .wbInfo,
        .invValid, .invSqN,
        .retValid, .retSqN, .retRd, .retValue,
        .retireCount, .trapCause, .trapPc, .halted, .redirValid, .redirPc,
        .archAddr, .archData
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic checkTrue(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s", msg);
            errors++;
        end
    endtask

    // compare one retired lane against the head of the program-order queue
    task automatic checkRetire(input int lane);
        logic [SQN_BITS-1:0] exp;
        if (expQ.size() == 0) begin
            checkTrue(1'b0, $sformatf("unexpected retire of sequence number %h on lane %0d",
                                      retSqN[lane], lane));
        end else begin
            exp = expQ.pop_front();
            checkValue("retSqN", XLEN'(retSqN[lane]), XLEN'(exp));
            if (sqnFlag[exp] == flagNone) begin
                checkValue("retRd", XLEN'(retRd[lane]), XLEN'(sqnRd[exp]));
                checkValue("retValue", retValue[lane], sqnVal[exp]);
                if (sqnRd[exp] != '0) begin
                    regModel[sqnRd[exp]] = sqnVal[exp];
                    regKnown[sqnRd[exp]] = 1'b1;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            for (int l = 0; l < COMMIT_WIDTH; l++) begin
                if (retValid[l]) begin
                    checkRetire(l);
                end
            end
            if (redirValid) begin
                redirSeen   = 1'b1;
                redirSeenPc = redirPc;
            end
        end
    end

    task automatic issue(input logic [XLEN-1:0] pc, input logic [REG_BITS-1:0] rd,
                         output logic [SQN_BITS-1:0] sqn);
        int waited;
        waited = 0;
        @(posedge clk);
        insValid <= 1'b1;
        insPc    <= pc;
        insRd    <= rd;
        @(negedge clk);
        while (!insReady && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        checkTrue(insReady, "insReady stayed low, instruction was not accepted");
        sqn          = modelSqN;
        sqnRd[sqn]   = rd;
        sqnVal[sqn]  = '0;
        sqnFlag[sqn] = flagNone;
        expQ.push_back(sqn);
        expCount++;
        modelSqN = modelSqN + SQN_BITS'(1);
        @(posedge clk);
        insValid <= 1'b0;
    endtask

    task automatic writeback(input int port, input logic [SQN_BITS-1:0] sqn,
                             input RobFlag flag, input logic [XLEN-1:0] value);
        sqnFlag[sqn] = flag;
        sqnVal[sqn]  = value;
        @(posedge clk);
        wbValid[port] <= 1'b1;
        wbSqN[port]   <= sqn;
        wbFlag[port]  <= flag;
        wbInfo[port]  <= WbInfo'(value);
        @(posedge clk);
        wbValid[port] <= 1'b0;
    endtask

    // everything younger than k leaves the model, dispatch restarts after k
    task automatic squashAfter(input logic [SQN_BITS-1:0] k);
        while (expQ.size() != 0 && expQ[$] != k) begin
            void'(expQ.pop_back());
            expCount--;
        end
        modelSqN = k + SQN_BITS'(1);
    endtask

    task automatic invalidate(input logic [SQN_BITS-1:0] k);
        @(posedge clk);
        invValid <= 1'b1;
        invSqN   <= k;
        @(posedge clk);
        invValid <= 1'b0;
        squashAfter(k);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (expQ.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        checkTrue(expQ.size() == 0,
                  $sformatf("%0d instructions did not retire in time", expQ.size()));
    endtask

    task automatic waitReady();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!insReady && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        checkTrue(insReady, "insReady did not rise after the head was freed");
    endtask

    task automatic waitRedirect();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!redirSeen && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        checkTrue(redirSeen, "no redirect seen after a flagged writeback");
    endtask

    task automatic checkRegs();
        for (int r = 0; r < 2**REG_BITS; r++) begin
            if (regKnown[r]) begin
                @(posedge clk);
                archAddr <= REG_BITS'(r);
                @(negedge clk);
                checkValue($sformatf("archData[x%0d]", r), archData, regModel[r]);
            end
        end
        checkValue("retireCount", retireCount, XLEN'(expCount));
    endtask

    task automatic finishTest(input string name, input int startErrors);
        testsRun++;
        if (errors == startErrors) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errors - startErrors);
        end
    endtask

    task automatic resetState();
        int startErrors;
        startErrors = errors;
        @(negedge clk);
        checkTrue(insReady, "insReady low after reset");
        checkTrue(retValid == '0 && !redirValid, "retire or redirect active after reset");
        checkTrue(!halted, "halted set after reset");
        checkValue("retireCount", retireCount, '0);
        finishTest("reset state", startErrors);
    endtask

    task automatic inOrderRetire();
        int                  startErrors;
        logic [SQN_BITS-1:0] sqns [8];
        startErrors = errors;
        for (int i = 0; i < 8; i++) begin
            issue(32'h1000 + 4 * i, REG_BITS'(i + 1), sqns[i]);
        end
        for (int i = 7; i >= 0; i--) begin
            writeback(i % 2, sqns[i], flagNone, 32'hA500_0000 + i);
        end
        drain();
        checkRegs();
        finishTest("in-order retire", startErrors);
    endtask

    task automatic backPressure();
        int                  startErrors;
        logic [SQN_BITS-1:0] sqns [ROB_LENGTH];
        startErrors = errors;
        for (int i = 0; i < ROB_LENGTH; i++) begin
            issue(32'h2000 + 4 * i, REG_BITS'(i + 8), sqns[i]);
        end
        @(negedge clk);
        checkTrue(!insReady, "insReady still high with a full window");
        writeback(0, sqns[0], flagNone, 32'hB000_0000);
        waitReady();
        for (int i = 1; i < ROB_LENGTH; i++) begin
            writeback(i % 2, sqns[i], flagNone, 32'hB000_0000 + i);
        end
        drain();
        checkRegs();
        finishTest("window back-pressure", startErrors);
    endtask

    task automatic invalidateYounger();
        int                  startErrors;
        logic [SQN_BITS-1:0] sqns [6];
        logic [SQN_BITS-1:0] fresh [2];
        startErrors = errors;
        // the three younger ones target registers that already hold values
        for (int i = 0; i < 6; i++) begin
            issue(32'h3000 + 4 * i, (i < 3) ? REG_BITS'(24 + i) : REG_BITS'(i - 2), sqns[i]);
        end
        // younger ones execute early so only the invalidate keeps them from retiring
        for (int i = 3; i < 6; i++) begin
            writeback(i % 2, sqns[i], flagNone, 32'hCBAD_0000 + i);
        end
        invalidate(sqns[2]);
        for (int i = 0; i < 3; i++) begin
            writeback(i % 2, sqns[i], flagNone, 32'hC000_0000 + i);
        end
        for (int i = 0; i < 2; i++) begin
            issue(32'h3100 + 4 * i, REG_BITS'(27 + i), fresh[i]);
            writeback(1, fresh[i], flagNone, 32'hC100_0000 + i);
        end
        drain();
        checkRegs();
        finishTest("invalidate", startErrors);
    endtask

    task automatic trapRedirect();
        int                  startErrors;
        logic [SQN_BITS-1:0] older;
        logic [SQN_BITS-1:0] trapped;
        logic [SQN_BITS-1:0] younger;
        startErrors = errors;
        issue(32'h4000, 5'd9, older);
        issue(32'h4004, 5'd10, trapped);
        issue(32'h4008, 5'd11, younger);
        squashAfter(trapped);
        redirSeen = 1'b0;
        writeback(1, younger, flagNone, 32'hBAD0_0001);
        writeback(0, trapped, flagTrap, {4'hB, 28'h0000ACE});
        writeback(1, older, flagNone, 32'hD000_0009);
        waitRedirect();
        checkValue("redirPc", redirSeenPc, TRAP_VECTOR);
        checkValue("trapCause", XLEN'(trapCause), 32'hB);
        checkValue("trapPc", trapPc, 32'h4004);
        drain();
        checkRegs();
        finishTest("trap", startErrors);
    endtask

    task automatic randomMix();
        int                  startErrors;
        int                  order [10];
        int                  j;
        int                  tmp;
        logic [SQN_BITS-1:0] sqns [10];
        startErrors = errors;
        for (int round = 0; round < 3; round++) begin
            for (int i = 0; i < 10; i++) begin
                issue(32'h6000 + 64 * round + 4 * i, REG_BITS'($urandom), sqns[i]);
                order[i] = i;
            end
            // shuffle the writeback order
            for (int i = 9; i > 0; i--) begin
                j        = int'($urandom % (i + 1));
                tmp      = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
            for (int i = 0; i < 10; i++) begin
                writeback(int'($urandom % 2), sqns[order[i]], flagNone, $urandom);
            end
            drain();
        end
        checkRegs();
        finishTest("random mix", startErrors);
    endtask

    task automatic fenceAndBreak();
        int                  startErrors;
        logic [SQN_BITS-1:0] fence;
        logic [SQN_BITS-1:0] later [2];
        logic [SQN_BITS-1:0] brk;
        startErrors = errors;
        issue(32'h5000, 5'd12, fence);
        redirSeen = 1'b0;
        writeback(0, fence, flagFence, '0);
        waitRedirect();
        checkValue("redirPc", redirSeenPc, 32'h5004);
        for (int i = 0; i < 2; i++) begin
            issue(32'h5004 + 4 * i, REG_BITS'(13 + i), later[i]);
            writeback(i, later[i], flagNone, 32'hE000_0000 + i);
        end
        drain();
        checkTrue(!halted, "halted set without a break");
        issue(32'h500C, 5'd15, brk);
        redirSeen = 1'b0;
        writeback(1, brk, flagBreak, '0);
        waitRedirect();
        checkValue("redirPc", redirSeenPc, 32'h5010);
        checkTrue(halted, "halted not set after a break retired");
        drain();
        checkRegs();
        finishTest("fence and break", startErrors);
    endtask

    initial begin
        void'($urandom(91567));
        rst      = 1'b1;
        insValid = 1'b0;
        insPc    = '0;
        insRd    = '0;
        wbValid  = '0;
        for (int p = 0; p < WB_PORTS; p++) begin
            wbSqN[p]  = '0;
            wbFlag[p] = flagNone;
            wbInfo[p] = '0;
        end
        invValid    = 1'b0;
        invSqN      = '0;
        archAddr    = '0;
        modelSqN    = '0;
        expCount    = 0;
        regModel[0] = '0;
        regKnown    = '0;
        regKnown[0] = 1'b1;
        redirSeen   = 1'b0;
        redirSeenPc = '0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        resetState();
        inOrderRetire();
        backPressure();
        invalidateYounger();
        trapRedirect();
        randomMix();
        fenceAndBreak();

        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 testsRun, testsFailed, errors, uut.rob.robChecks.failCount);
        if (errors == 0 && uut.rob.robChecks.failCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== test/robCore_assertions.sv ====
`timescale 1ns/100ps

module robCoreAssertions import robPkg::*; #(
    parameter int COMMIT_WIDTH = 2
) (
    input logic                    clk,
    input logic                    rst,
    input logic [COMMIT_WIDTH-1:0] comValid,
    input RobFlag                  comFlag0,
    input logic                    redirValid,
    input logic                    enqValid,
    input logic [SQN_BITS-1:0]     enqSqN,
    input logic [SQN_BITS-1:0]     maxSqN
);

    int                         failCount = 0;
    logic                       flagPending;
    logic signed [SQN_BITS-1:0] windowGap;

    // open from a flagged commit until the redirect comes back
    always_ff @(posedge clk) begin
        if (rst || redirValid) begin
            flagPending <= 1'b0;
        end else if (comValid[0] && comFlag0 != flagNone) begin
            flagPending <= 1'b1;
        end
    end

    assign windowGap = enqSqN - maxSqN;

    lane0First: assert property (@(posedge clk) disable iff (rst)
        (comValid >> 1) != '0 |-> comValid[0])
        else begin
            $error("commit on an upper lane without lane 0");
            failCount++;
        end

    noCommitAfterFlag: assert property (@(posedge clk) disable iff (rst)
        flagPending |-> comValid == '0)
        else begin
            $error("commit between a flagged commit and its redirect");
            failCount++;
        end

    enqInsideWindow: assert property (@(posedge clk) disable iff (rst)
        enqValid |-> windowGap <= 0)
        else begin
            $error("enqueued sequence number lies beyond maxSqN");
            failCount++;
        end

endmodule

bind reorderBuffer robCoreAssertions #(.COMMIT_WIDTH(COMMIT_WIDTH)) robChecks (
    .clk(clk),
    .rst(rst),
    .comValid(comValid),
    .comFlag0(comFlag[0]),
    .redirValid(redirValid),
    .enqValid(enqValid),
    .enqSqN(enqSqN),
    .maxSqN(maxSqN)
);
